// ==== logic/tile_noc_pkg.sv ====
package tile_noc_pkg;

  // coordinate and payload widths
  localparam int X_CORD_W  = 4;
  localparam int Y_CORD_W  = 4;
  localparam int ADDR_W    = 8;
  localparam int DATA_W    = 32;
  localparam int DIR_IDX_W = 3;

  typedef logic [X_CORD_W-1:0]  x_cord_t;
  typedef logic [Y_CORD_W-1:0]  y_cord_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [DIR_IDX_W-1:0] dir_t;

  // router and barrier port order, matches the mesh numbering
  localparam dir_t P  = 3'd0;
  localparam dir_t W  = 3'd1;
  localparam dir_t E  = 3'd2;
  localparam dir_t N  = 3'd3;
  localparam dir_t S  = 3'd4;
  localparam dir_t RW = 3'd5;
  localparam dir_t RE = 3'd6;

  localparam int NUM_DIRS     = 7;
  // skip distance in X, also the lane count
  localparam int RUCHE_FACTOR = 3;

  typedef enum logic [1:0] {
    op_store,
    op_load,
    op_reply
  } pkt_op_t;

  // single-flit packet, always with full coordinates
  typedef struct packed {
    pkt_op_t op;
    x_cord_t dest_x;
    y_cord_t dest_y;
    x_cord_t src_x;
    y_cord_t src_y;
    addr_t   addr;
    data_t   data;
  } noc_pkt_t;

endpackage

// ==== logic/tile_core_pkg.sv ====
package tile_core_pkg;

  // local data memory
  localparam int DMEM_WORDS = 16;
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

  typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;

  // barrier config register
  // data[6:0] source mask, data[10:8] destination direction
  localparam tile_noc_pkg::addr_t BAR_CFG_ADDR = 8'h80;
  localparam int BAR_DEST_LSB = 8;

  // barrier arrive register
  localparam tile_noc_pkg::addr_t BAR_ARRIVE_ADDR = 8'h81;
  // store sets arrive, load sees arrive and done
  localparam int BAR_ARRIVE_BIT = 0;
  localparam int BAR_DONE_BIT   = 1;

endpackage

// ==== logic/tile_link_if.sv ====
`timescale 1ns/1ps

// one directed packet link, valid/ready handshake
interface tile_link_if;
  import tile_noc_pkg::*;

  logic     valid;
  logic     ready;
  noc_pkt_t pkt;

  // holds valid and pkt until ready is seen
  modport sender (
    output valid,
    output pkt,
    input  ready
  );

  modport receiver (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

// ==== logic/mesh_router.sv ====
`timescale 1ns/1ps

module mesh_router (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  tile_noc_pkg::x_cord_t my_x_i,
  input  tile_noc_pkg::y_cord_t my_y_i,
  tile_link_if.receiver         link_in  [tile_noc_pkg::NUM_DIRS],
  tile_link_if.sender           link_out [tile_noc_pkg::NUM_DIRS]
);
  import tile_noc_pkg::*;

  logic     [NUM_DIRS-1:0] in_v;
  noc_pkt_t                in_pkt  [NUM_DIRS];
  logic     [NUM_DIRS-1:0] buf_v;
  noc_pkt_t                buf_pkt [NUM_DIRS];
  dir_t                    route   [NUM_DIRS];
  logic     [NUM_DIRS-1:0] deq;
  logic     [NUM_DIRS-1:0] req     [NUM_DIRS];
  logic     [NUM_DIRS-1:0] out_v;
  logic     [NUM_DIRS-1:0] out_rdy;
  noc_pkt_t                out_pkt [NUM_DIRS];
  dir_t                    out_sel [NUM_DIRS];
  logic     [NUM_DIRS-1:0] lock_r;
  dir_t                    owner_r [NUM_DIRS];
  dir_t                    last_r  [NUM_DIRS];

  // X first, long hops take the ruche port
  function automatic dir_t route_dir(noc_pkt_t pkt, x_cord_t x, y_cord_t y);
    dir_t dir;
    if (pkt.dest_x > x) begin
      dir = (pkt.dest_x - x >= RUCHE_FACTOR) ? RE : E;
    end else if (pkt.dest_x < x) begin
      dir = (x - pkt.dest_x >= RUCHE_FACTOR) ? RW : W;
    end else if (pkt.dest_y < y) begin
      dir = N;
    end else if (pkt.dest_y > y) begin
      dir = S;
    end else begin
      dir = P;
    end
    return dir;
  endfunction

  // first requester after the last winner, last winner lowest
  function automatic dir_t rr_pick(logic [NUM_DIRS-1:0] reqs, dir_t last);
    dir_t pick;
    int   idx;
    pick = last;
    for (int k = NUM_DIRS; k >= 1; k--) begin
      idx = (int'(last) + k) % NUM_DIRS;
      if (reqs[idx]) begin
        pick = dir_t'(idx);
      end
    end
    return pick;
  endfunction

  for (genvar d = 0; d < NUM_DIRS; d++) begin : g_port
    assign in_v[d]           = link_in[d].valid;
    assign in_pkt[d]         = link_in[d].pkt;
    assign link_in[d].ready  = ~buf_v[d];
    assign route[d]          = route_dir(buf_pkt[d], my_x_i, my_y_i);
    assign link_out[d].valid = out_v[d];
    assign link_out[d].pkt   = out_pkt[d];
    assign out_rdy[d]        = link_out[d].ready;
  end

  // one-entry buffer per input
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_v <= '0;
    end else begin
      buf_v <= (buf_v & ~deq) | (in_v & ~buf_v);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_DIRS; i++) begin
      if (in_v[i] && !buf_v[i]) begin
        buf_pkt[i] <= in_pkt[i];
      end
    end
  end

  always_comb begin
    deq = '0;
    for (int o = 0; o < NUM_DIRS; o++) begin
      // u-turns are not part of the crossbar
      for (int i = 0; i < NUM_DIRS; i++) begin
        req[o][i] = buf_v[i] && (route[i] == dir_t'(o)) && (i != o);
      end
      out_sel[o] = lock_r[o] ? owner_r[o] : rr_pick(req[o], last_r[o]);
      out_v[o]   = lock_r[o] || (|req[o]);
      out_pkt[o] = buf_pkt[out_sel[o]];
      if (out_v[o] && out_rdy[o]) begin
        deq[out_sel[o]] = 1'b1;
      end
    end
  end

  // grant is held while the output is stalled
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_r <= '0;
      for (int o = 0; o < NUM_DIRS; o++) begin
        owner_r[o] <= P;
        last_r[o]  <= P;
      end
    end else begin
      for (int o = 0; o < NUM_DIRS; o++) begin
        if (out_v[o] && out_rdy[o]) begin
          lock_r[o] <= 1'b0;
          last_r[o] <= out_sel[o];
        end else if (out_v[o]) begin
          lock_r[o]  <= 1'b1;
          owner_r[o] <= out_sel[o];
        end
      end
    end
  end

endmodule

// ==== logic/barrier_node.sv ====
`timescale 1ns/1ps

module barrier_node (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic [tile_noc_pkg::NUM_DIRS-1:0] data_i,
  output logic [tile_noc_pkg::NUM_DIRS-1:0] data_o,
  input  logic [tile_noc_pkg::NUM_DIRS-1:0] src_mask_i,
  input  tile_noc_pkg::dir_t                dest_i
);
  import tile_noc_pkg::*;

  logic all_in;
  logic done_r;

  // unmasked directions count as arrived
  // empty mask never completes
  assign all_in = (|src_mask_i) & (&(data_i | ~src_mask_i));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_r <= 1'b0;
    end else begin
      done_r <= all_in;
    end
  end

  // result goes out on one direction only
  always_comb begin
    for (int d = 0; d < NUM_DIRS; d++) begin
      data_o[d] = done_r && (dest_i == dir_t'(d));
    end
  end

endmodule

// ==== logic/tile_endpoint.sv ====
`timescale 1ns/1ps

module tile_endpoint (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  tile_noc_pkg::x_cord_t             my_x_i,
  input  tile_noc_pkg::y_cord_t             my_y_i,
  tile_link_if.receiver                     req,
  tile_link_if.sender                       rsp,
  input  logic                              barrier_data_i,
  output logic                              barrier_data_o,
  output logic [tile_noc_pkg::NUM_DIRS-1:0] bar_src_mask_o,
  output tile_noc_pkg::dir_t                bar_dest_o
);
  import tile_noc_pkg::*;
  import tile_core_pkg::*;

  data_t               dmem [DMEM_WORDS];
  logic                rsp_v_r;
  noc_pkt_t            rsp_pkt_r;
  logic                arrive_r;
  logic                done_r;
  logic [NUM_DIRS-1:0] mask_r;
  dir_t                dest_r;

  noc_pkt_t            req_pkt;
  logic                req_xfer;
  logic                is_dmem;
  logic                st_acc;
  logic                ld_acc;
  dmem_idx_t           dmem_idx;
  data_t               load_data;

  // stall requests while a reply is pending
  assign req.ready = ~rsp_v_r;
  assign req_xfer  = req.valid & req.ready;
  assign req_pkt   = req.pkt;
  assign is_dmem   = req_pkt.addr < DMEM_WORDS;
  assign dmem_idx  = req_pkt.addr[DMEM_IDX_W-1:0];
  assign st_acc    = req_xfer && (req_pkt.op == op_store);
  assign ld_acc    = req_xfer && (req_pkt.op == op_load);

  always_comb begin
    load_data = '0;
    if (is_dmem) begin
      load_data = dmem[dmem_idx];
    end else if (req_pkt.addr == BAR_CFG_ADDR) begin
      load_data[NUM_DIRS-1:0] = mask_r;
      load_data[BAR_DEST_LSB +: DIR_IDX_W] = dest_r;
    end else if (req_pkt.addr == BAR_ARRIVE_ADDR) begin
      load_data[BAR_ARRIVE_BIT] = arrive_r;
      load_data[BAR_DONE_BIT]   = done_r;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_v_r  <= 1'b0;
      arrive_r <= 1'b0;
      done_r   <= 1'b0;
      mask_r   <= '0;
      dest_r   <= P;
    end else begin
      if (ld_acc) begin
        rsp_v_r <= 1'b1;
      end else if (rsp.ready) begin
        rsp_v_r <= 1'b0;
      end
      // barrier completion seen on the local port
      if (arrive_r && barrier_data_i) begin
        arrive_r <= 1'b0;
        done_r   <= 1'b1;
      end
      if (st_acc && (req_pkt.addr == BAR_ARRIVE_ADDR) && req_pkt.data[BAR_ARRIVE_BIT]) begin
        arrive_r <= 1'b1;
        done_r   <= 1'b0;
      end
      if (st_acc && (req_pkt.addr == BAR_CFG_ADDR)) begin
        mask_r <= req_pkt.data[NUM_DIRS-1:0];
        dest_r <= req_pkt.data[BAR_DEST_LSB +: DIR_IDX_W];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_acc && is_dmem) begin
      dmem[dmem_idx] <= req_pkt.data;
    end
    // reply heads back to the requester
    if (ld_acc) begin
      rsp_pkt_r.op     <= op_reply;
      rsp_pkt_r.dest_x <= req_pkt.src_x;
      rsp_pkt_r.dest_y <= req_pkt.src_y;
      rsp_pkt_r.src_x  <= my_x_i;
      rsp_pkt_r.src_y  <= my_y_i;
      rsp_pkt_r.addr   <= req_pkt.addr;
      rsp_pkt_r.data   <= load_data;
    end
  end

  assign rsp.valid      = rsp_v_r;
  assign rsp.pkt        = rsp_pkt_r;
  assign barrier_data_o = arrive_r;
  assign bar_src_mask_o = mask_r;
  assign bar_dest_o     = dest_r;

endmodule

// ==== logic/compute_tile.sv ====
`timescale 1ns/1ps

module compute_tile (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  output logic                                         reset_n_o,
  input  tile_noc_pkg::x_cord_t                        global_x_i,
  input  tile_noc_pkg::y_cord_t                        global_y_i,
  output tile_noc_pkg::x_cord_t                        global_x_o,
  output tile_noc_pkg::y_cord_t                        global_y_o,
  // local mesh links, indexed W..S
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]       link_v_i,
  input  tile_noc_pkg::noc_pkt_t [tile_noc_pkg::S:tile_noc_pkg::W] link_pkt_i,
  output logic [tile_noc_pkg::S:tile_noc_pkg::W]       link_ready_o,
  output logic [tile_noc_pkg::S:tile_noc_pkg::W]       link_v_o,
  output tile_noc_pkg::noc_pkt_t [tile_noc_pkg::S:tile_noc_pkg::W] link_pkt_o,
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]       link_ready_i,
  // ruche links, lane then side
  input  logic [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_v_i,
  input  tile_noc_pkg::noc_pkt_t
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_pkt_i,
  output logic
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_ready_o,
  output logic [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_v_o,
  output tile_noc_pkg::noc_pkt_t
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_pkt_o,
  input  logic
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] ruche_link_ready_i,
  // barrier levels
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]       barrier_link_i,
  output logic [tile_noc_pkg::S:tile_noc_pkg::W]       barrier_link_o,
  input  logic
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] barrier_ruche_link_i,
  output logic
         [tile_noc_pkg::RUCHE_FACTOR-1:0][tile_noc_pkg::E:tile_noc_pkg::W] barrier_ruche_link_o
);
  import tile_noc_pkg::*;

  logic                reset_n_r;
  x_cord_t             my_x_r;
  y_cord_t             my_y_r;
  logic [NUM_DIRS-1:0] barr_in;
  logic [NUM_DIRS-1:0] barr_out;
  logic [NUM_DIRS-1:0] bar_src_mask;
  dir_t                bar_dest;

  // reset and coordinates are retimed in every tile
  always_ff @(posedge clk_i) begin
    reset_n_r <= arst_n_i;
    my_x_r    <= global_x_i;
    my_y_r    <= global_y_i;
  end

  assign reset_n_o  = reset_n_r;
  assign global_x_o = my_x_r;
  assign global_y_o = y_cord_t'(my_y_r + 1'b1);

  tile_link_if rtr_in  [NUM_DIRS] ();
  tile_link_if rtr_out [NUM_DIRS] ();

  mesh_router u_router (
    .clk_i    (clk_i),
    .arst_n_i (reset_n_r),
    .my_x_i   (my_x_r),
    .my_y_i   (my_y_r),
    .link_in  (rtr_in),
    .link_out (rtr_out)
  );

  tile_endpoint u_endpoint (
    .clk_i          (clk_i),
    .arst_n_i       (reset_n_r),
    .my_x_i         (my_x_r),
    .my_y_i         (my_y_r),
    .req            (rtr_out[P]),
    .rsp            (rtr_in[P]),
    .barrier_data_i (barr_out[P]),
    .barrier_data_o (barr_in[P]),
    .bar_src_mask_o (bar_src_mask),
    .bar_dest_o     (bar_dest)
  );

  barrier_node u_barrier (
    .clk_i      (clk_i),
    .arst_n_i   (reset_n_r),
    .data_i     (barr_in),
    .data_o     (barr_out),
    .src_mask_i (bar_src_mask),
    .dest_i     (bar_dest)
  );

  for (genvar d = W; d <= S; d++) begin : g_local
    assign rtr_in[d].valid  = link_v_i[d];
    assign rtr_in[d].pkt    = link_pkt_i[d];
    assign link_ready_o[d]  = rtr_in[d].ready;
    assign link_v_o[d]      = rtr_out[d].valid;
    assign link_pkt_o[d]    = rtr_out[d].pkt;
    assign rtr_out[d].ready = link_ready_i[d];
  end

  // lane 0 ends here, W side on RW and E side on RE
  assign rtr_in[RW].valid         = ruche_link_v_i[0][W];
  assign rtr_in[RW].pkt           = ruche_link_pkt_i[0][W];
  assign ruche_link_ready_o[0][W] = rtr_in[RW].ready;
  assign ruche_link_v_o[0][W]     = rtr_out[RW].valid;
  assign ruche_link_pkt_o[0][W]   = rtr_out[RW].pkt;
  assign rtr_out[RW].ready        = ruche_link_ready_i[0][W];
  assign rtr_in[RE].valid         = ruche_link_v_i[0][E];
  assign rtr_in[RE].pkt           = ruche_link_pkt_i[0][E];
  assign ruche_link_ready_o[0][E] = rtr_in[RE].ready;
  assign ruche_link_v_o[0][E]     = rtr_out[RE].valid;
  assign ruche_link_pkt_o[0][E]   = rtr_out[RE].pkt;
  assign rtr_out[RE].ready        = ruche_link_ready_i[0][E];

  // other lanes cross the tile untouched
  for (genvar l = 1; l < RUCHE_FACTOR; l++) begin : g_ruche_ft
    assign ruche_link_v_o[l][E]       = ruche_link_v_i[l][W];
    assign ruche_link_pkt_o[l][E]     = ruche_link_pkt_i[l][W];
    assign ruche_link_ready_o[l][W]   = ruche_link_ready_i[l][E];
    assign ruche_link_v_o[l][W]       = ruche_link_v_i[l][E];
    assign ruche_link_pkt_o[l][W]     = ruche_link_pkt_i[l][E];
    assign ruche_link_ready_o[l][E]   = ruche_link_ready_i[l][W];
    assign barrier_ruche_link_o[l][E] = barrier_ruche_link_i[l][W];
    assign barrier_ruche_link_o[l][W] = barrier_ruche_link_i[l][E];
  end

  assign barr_in[S:W]               = barrier_link_i;
  assign barrier_link_o             = barr_out[S:W];
  assign barr_in[RW]                = barrier_ruche_link_i[0][W];
  assign barr_in[RE]                = barrier_ruche_link_i[0][E];
  assign barrier_ruche_link_o[0][W] = barr_out[RW];
  assign barrier_ruche_link_o[0][E] = barr_out[RE];

endmodule

// ==== bench/compute_tile_sva.sv ====
`timescale 1ns/1ps

module compute_tile_sva (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]                   link_v_o,
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]                   link_ready_i,
  input  tile_noc_pkg::noc_pkt_t [tile_noc_pkg::S:tile_noc_pkg::W] link_pkt_o,
  input  logic [tile_noc_pkg::S:tile_noc_pkg::W]                   barrier_link_o,
  input  tile_noc_pkg::dir_t                                       bar_dest_i
);
  import tile_noc_pkg::*;

  int fail_count = 0;

  for (genvar d = W; d <= S; d++) begin : g_dir
    // stalled packet stays on the link
    assert property (@(posedge clk_i) disable iff (rst_n_i !== 1'b1)
      link_v_o[d] && !link_ready_i[d] |=> link_v_o[d] && $stable(link_pkt_o[d]))
    else begin
      $error("valid or packet changed while stalled on port %0d", d);
      fail_count++;
    end

    assert property (@(posedge clk_i) disable iff (rst_n_i !== 1'b1)
      link_v_o[d] |-> link_pkt_o[d].op inside {op_store, op_load, op_reply})
    else begin
      $error("illegal op on port %0d", d);
      fail_count++;
    end

    // only the selected direction carries the barrier result
    assert property (@(posedge clk_i) disable iff (rst_n_i !== 1'b1)
      (bar_dest_i != dir_t'(d)) |-> !barrier_link_o[d])
    else begin
      $error("barrier output high off destination on port %0d", d);
      fail_count++;
    end
  end

endmodule

// ==== bench/compute_tile_tb.sv ====
`timescale 1ns/1ps

module compute_tile_tb;
  import tile_noc_pkg::*;
  import tile_core_pkg::*;

  localparam int          N_ROWS          = 13;
  localparam int          WATCHDOG_CYCLES = N_ROWS * 50;
  localparam int unsigned SEED            = 32'h3f5aa52c;
  localparam x_cord_t     TILE_X          = 4'd5;
  localparam y_cord_t     TILE_Y          = 4'd5;
  // ruche port codes use lane + 1 as tens digit and side as units digit
  localparam int R0W = 11;
  localparam int R0E = 12;
  localparam int R1W = 21;
  localparam int R1E = 22;
  localparam int R2W = 31;
  localparam int R2E = 32;

  typedef struct {
    int       in_port;
    noc_pkt_t pkt;
    int       out_port;
    noc_pkt_t exp_pkt;
  } row_t;

  logic                                      clk;
  logic                                      arst_n;
  logic                                      rst_n_o;
  x_cord_t                                   gx_i;
  x_cord_t                                   gx_o;
  y_cord_t                                   gy_i;
  y_cord_t                                   gy_o;
  logic [S:W]                                link_v_i;
  logic [S:W]                                link_ready_o;
  logic [S:W]                                link_v_o;
  logic [S:W]                                link_ready_i;
  noc_pkt_t [S:W]                            link_pkt_i;
  noc_pkt_t [S:W]                            link_pkt_o;
  logic [RUCHE_FACTOR-1:0][E:W]              r_v_i;
  logic [RUCHE_FACTOR-1:0][E:W]              r_ready_o;
  logic [RUCHE_FACTOR-1:0][E:W]              r_v_o;
  logic [RUCHE_FACTOR-1:0][E:W]              r_ready_i;
  noc_pkt_t [RUCHE_FACTOR-1:0][E:W]          r_pkt_i;
  noc_pkt_t [RUCHE_FACTOR-1:0][E:W]          r_pkt_o;
  logic [S:W]                                bar_i;
  logic [S:W]                                bar_o;
  logic [RUCHE_FACTOR-1:0][E:W]              bar_r_i;
  logic [RUCHE_FACTOR-1:0][E:W]              bar_r_o;

  int   n_checks;
  int   n_errors;
  row_t rows [N_ROWS];

  compute_tile UUT (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .reset_n_o            (rst_n_o),
    .global_x_i           (gx_i),
    .global_y_i           (gy_i),
    .global_x_o           (gx_o),
    .global_y_o           (gy_o),
    .link_v_i             (link_v_i),
    .link_pkt_i           (link_pkt_i),
    .link_ready_o         (link_ready_o),
    .link_v_o             (link_v_o),
    .link_pkt_o           (link_pkt_o),
    .link_ready_i         (link_ready_i),
    .ruche_link_v_i       (r_v_i),
    .ruche_link_pkt_i     (r_pkt_i),
    .ruche_link_ready_o   (r_ready_o),
    .ruche_link_v_o       (r_v_o),
    .ruche_link_pkt_o     (r_pkt_o),
    .ruche_link_ready_i   (r_ready_i),
    .barrier_link_i       (bar_i),
    .barrier_link_o       (bar_o),
    .barrier_ruche_link_i (bar_r_i),
    .barrier_ruche_link_o (bar_r_o)
  );

  bind compute_tile compute_tile_sva u_sva (
    .clk_i          (clk_i),
    .rst_n_i        (reset_n_r),
    .link_v_o       (link_v_o),
    .link_ready_i   (link_ready_i),
    .link_pkt_o     (link_pkt_o),
    .barrier_link_o (barrier_link_o),
    .bar_dest_i     (bar_dest)
  );

  always #5 clk = ~clk;

  function automatic noc_pkt_t make_pkt(pkt_op_t op, x_cord_t dx, y_cord_t dy,
                                        x_cord_t sx, y_cord_t sy, addr_t addr, data_t data);
    noc_pkt_t p;
    p.op     = op;
    p.dest_x = dx;
    p.dest_y = dy;
    p.src_x  = sx;
    p.src_y  = sy;
    p.addr   = addr;
    p.data   = data;
    return p;
  endfunction

  // config word with mask in 6:0 and destination in 10:8
  function automatic data_t bar_cfg(logic [NUM_DIRS-1:0] mask, dir_t dest);
    data_t d;
    d       = '0;
    d[6:0]  = mask;
    d[10:8] = dest;
    return d;
  endfunction

  function automatic string port_name(int code);
    if (code >= 10) begin
      return $sformatf("ruche_link_pkt_o[%0d][%s]", code / 10 - 1, (code % 10 == E) ? "E" : "W");
    end
    return $sformatf("link_pkt_o[%0d]", code);
  endfunction

  function automatic logic in_ready(int code);
    return (code >= 10) ? r_ready_o[code / 10 - 1][code % 10] : link_ready_o[code];
  endfunction

  function automatic logic out_valid(int code);
    return (code >= 10) ? r_v_o[code / 10 - 1][code % 10] : link_v_o[code];
  endfunction

  function automatic logic out_ready(int code);
    return (code >= 10) ? r_ready_i[code / 10 - 1][code % 10] : link_ready_i[code];
  endfunction

  function automatic noc_pkt_t out_pkt(int code);
    return (code >= 10) ? r_pkt_o[code / 10 - 1][code % 10] : link_pkt_o[code];
  endfunction

  task automatic set_in(int code, logic v, noc_pkt_t p);
    if (code >= 10) begin
      r_v_i[code / 10 - 1][code % 10]   = v;
      r_pkt_i[code / 10 - 1][code % 10] = p;
    end else begin
      link_v_i[code]   = v;
      link_pkt_i[code] = p;
    end
  endtask

  task automatic set_out_ready(int code, logic r);
    if (code >= 10) begin
      r_ready_i[code / 10 - 1][code % 10] = r;
    end else if (code != 0) begin
      link_ready_i[code] = r;
    end
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // entered and left on a falling edge
  task automatic drive_pkt(int code, noc_pkt_t p);
    set_in(code, 1'b1, p);
    #1;
    while (!in_ready(code)) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    set_in(code, 1'b0, '0);
  endtask

  task automatic expect_pkt(int code, noc_pkt_t exp);
    noc_pkt_t got;
    if (code != 0) begin
      #1;
      while (!(out_valid(code) && out_ready(code))) begin
        @(negedge clk);
        #1;
      end
      got = out_pkt(code);
      check_val(port_name(code), got, exp);
      @(negedge clk);
    end
  endtask

  task automatic release_ready(int code, int cycles);
    repeat (cycles) @(negedge clk);
    set_out_ready(code, 1'b1);
  endtask

  task automatic set_row(int idx, int in_port, noc_pkt_t p, int out_port, noc_pkt_t e);
    rows[idx].in_port  = in_port;
    rows[idx].pkt      = p;
    rows[idx].out_port = out_port;
    rows[idx].exp_pkt  = e;
  endtask

  task automatic load_table();
    noc_pkt_t p;
    p = make_pkt(op_store, 4'd6, TILE_Y, 4'd4, TILE_Y, 8'h01, 32'h0000_6501);
    set_row(0, W, p, E, p);
    p = make_pkt(op_store, 4'd4, TILE_Y, 4'd6, TILE_Y, 8'h02, 32'h0000_4502);
    set_row(1, E, p, W, p);
    p = make_pkt(op_store, TILE_X, 4'd3, TILE_X, 4'd6, 8'h03, 32'h0000_5303);
    set_row(2, S, p, N, p);
    p = make_pkt(op_store, TILE_X, 4'd7, TILE_X, 4'd4, 8'h04, 32'h0000_5704);
    set_row(3, N, p, S, p);
    // three or more hops take the ruche port
    p = make_pkt(op_store, 4'd8, TILE_Y, 4'd4, TILE_Y, 8'h05, 32'h0000_8505);
    set_row(4, W, p, R0E, p);
    p = make_pkt(op_store, 4'd2, TILE_Y, 4'd6, TILE_Y, 8'h06, 32'h0000_2506);
    set_row(5, E, p, R0W, p);
    p = make_pkt(op_load, 4'd6, TILE_Y, 4'd2, TILE_Y, 8'h07, 32'h0000_6507);
    set_row(6, R0W, p, E, p);
    // lanes 1 and 2 only pass through
    p = make_pkt(op_store, 4'd9, TILE_Y, 4'd3, TILE_Y, 8'h08, 32'h1111_0008);
    set_row(7, R1W, p, R1E, p);
    p = make_pkt(op_reply, 4'd1, TILE_Y, 4'd7, TILE_Y, 8'h09, 32'h1111_0009);
    set_row(8, R1E, p, R1W, p);
    p = make_pkt(op_load, 4'd10, 4'd2, 4'd2, 4'd2, 8'h0a, 32'h2222_000a);
    set_row(9, R2W, p, R2E, p);
    p = make_pkt(op_store, 4'd0, 4'd8, 4'd8, 4'd8, 8'h0b, 32'h2222_000b);
    set_row(10, R2E, p, R2W, p);
    p = make_pkt(op_store, TILE_X, TILE_Y, 4'd4, TILE_Y, 8'h03, 32'hcafe_0003);
    set_row(11, W, p, 0, '0);
    p = make_pkt(op_load, TILE_X, TILE_Y, TILE_X, 4'd2, 8'h03, '0);
    set_row(12, N, p, N, make_pkt(op_reply, TILE_X, 4'd2, TILE_X, TILE_Y, 8'h03, 32'hcafe_0003));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int       stall;
    noc_pkt_t pkt_a;
    noc_pkt_t pkt_b;
    void'($urandom(SEED));
    n_checks     = 0;
    n_errors     = 0;
    clk          = 1'b0;
    arst_n       = 1'b0;
    gx_i         = TILE_X;
    gy_i         = TILE_Y;
    link_v_i     = '0;
    link_pkt_i   = '0;
    link_ready_i = '1;
    r_v_i        = '0;
    r_pkt_i      = '0;
    r_ready_i    = '1;
    bar_i        = '0;
    bar_r_i      = '0;
    load_table();

    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    // release shows up only after the next rising edge
    #1;
    check_val("reset_n_o", rst_n_o, 1'b0);
    @(negedge clk);
    check_val("reset_n_o", rst_n_o, 1'b1);
    check_val("global_x_o", gx_o, TILE_X);
    check_val("global_y_o", gy_o, TILE_Y + 1);

    for (int r = 0; r < N_ROWS; r++) begin
      stall = 0;
      // some rows see their output stalled for a few cycles
      if (rows[r].out_port != 0 && $urandom % 2 == 1) begin
        stall = 1 + $urandom % 3;
        set_out_ready(rows[r].out_port, 1'b0);
      end
      fork
        drive_pkt(rows[r].in_port, rows[r].pkt);
        expect_pkt(rows[r].out_port, rows[r].exp_pkt);
        release_ready(rows[r].out_port, stall);
      join
    end

    // two eastbound packets behind a stalled E link
    pkt_a = make_pkt(op_store, 4'd6, TILE_Y, 4'd4, TILE_Y, 8'h10, 32'h1111_aaaa);
    pkt_b = make_pkt(op_store, 4'd6, TILE_Y, 4'd4, TILE_Y, 8'h11, 32'h2222_bbbb);
    set_out_ready(E, 1'b0);
    fork
      begin
        drive_pkt(W, pkt_a);
        drive_pkt(W, pkt_b);
      end
      begin
        repeat (4) @(negedge clk);
        #1;
        check_val("link_v_o[E]", link_v_o[E], 1'b1);
        check_val("link_pkt_o[E]", link_pkt_o[E], pkt_a);
        check_val("link_ready_o[W]", link_ready_o[W], 1'b0);
        @(negedge clk);
        set_out_ready(E, 1'b1);
      end
      begin
        expect_pkt(E, pkt_a);
        expect_pkt(E, pkt_b);
      end
    join

    // barrier over P and W with the result toward E
    drive_pkt(W, make_pkt(op_store, TILE_X, TILE_Y, 4'd4, TILE_Y, BAR_CFG_ADDR,
                          bar_cfg((7'd1 << P) | (7'd1 << W), E)));
    drive_pkt(W, make_pkt(op_store, TILE_X, TILE_Y, 4'd4, TILE_Y, BAR_ARRIVE_ADDR, 32'd1));
    repeat (4) begin
      @(negedge clk);
      check_val("barrier_link_o[E]", bar_o[E], 1'b0);
    end
    bar_i[W] = 1'b1;
    @(negedge clk);
    check_val("barrier_link_o[E]", bar_o[E], 1'b1);
    // pointing the result at P completes the local arrive
    drive_pkt(W, make_pkt(op_store, TILE_X, TILE_Y, 4'd4, TILE_Y, BAR_CFG_ADDR,
                          bar_cfg((7'd1 << P) | (7'd1 << W), P)));
    fork
      drive_pkt(W, make_pkt(op_load, TILE_X, TILE_Y, 4'd4, TILE_Y, BAR_ARRIVE_ADDR, '0));
      expect_pkt(W, make_pkt(op_reply, 4'd4, TILE_Y, TILE_X, TILE_Y, BAR_ARRIVE_ADDR, 32'h2));
    join
    bar_i[W] = 1'b0;

    // coordinates move one cycle behind the inputs
    gx_i = 4'd7;
    gy_i = 4'd9;
    #1;
    check_val("global_x_o", gx_o, TILE_X);
    check_val("global_y_o", gy_o, TILE_Y + 1);
    @(negedge clk);
    check_val("global_x_o", gx_o, 4'd7);
    check_val("global_y_o", gy_o, 4'd10);
    gx_i = TILE_X;
    gy_i = TILE_Y;
    @(negedge clk);

    // barrier levels on lanes 1 and 2 cross to the far side
    for (int l = 1; l < RUCHE_FACTOR; l++) begin
      bar_r_i[l][W] = 1'b1;
      #1;
      check_val($sformatf("barrier_ruche_link_o[%0d][E]", l), bar_r_o[l][E], 1'b1);
      check_val($sformatf("barrier_ruche_link_o[%0d][W]", l), bar_r_o[l][W], 1'b0);
      @(negedge clk);
      bar_r_i[l][W] = 1'b0;
      bar_r_i[l][E] = 1'b1;
      #1;
      check_val($sformatf("barrier_ruche_link_o[%0d][W]", l), bar_r_o[l][W], 1'b1);
      check_val($sformatf("barrier_ruche_link_o[%0d][E]", l), bar_r_o[l][E], 1'b0);
      @(negedge clk);
      bar_r_i[l][E] = 1'b0;
    end
    // result points at P so lane 0 stays low
    check_val("barrier_ruche_link_o[0]", bar_r_o[0], 2'b00);
    @(negedge clk);

    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             n_checks, n_errors, UUT.u_sva.fail_count);
    if (n_errors == 0 && UUT.u_sva.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== compute_tile.f ====
logic/tile_noc_pkg.sv
logic/tile_core_pkg.sv
logic/tile_link_if.sv
logic/mesh_router.sv
logic/barrier_node.sv
logic/tile_endpoint.sv
logic/compute_tile.sv
bench/compute_tile_sva.sv
bench/compute_tile_tb.sv
